/* logic/hidden_state.sv */
`timescale 1ns/1ps
`default_nettype none

module hidden_state
(
    input  logic clk,
    input  logic reset,
    input  logic embed_we,
    input  logic neuron_we,
    input  logic [2:0] neuron_idx,
    input  logic [2:0] operand_idx,
    input  logic operand_from_embed,
    input  rnn_pkg::word_t wdata,
    input  rnn_pkg::word_t acc_value,
    input  logic commit,
    output rnn_pkg::word_t operand,
    output rnn_pkg::hidden_vec_t hidden
);

    rnn_pkg::word_t [rnn_pkg::EMBEDDING_SIZE-1:0] emb;
    rnn_pkg::hidden_vec_t h_old;
    rnn_pkg::hidden_vec_t h_new;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            emb   <= '0;
            h_old <= '0;
            h_new <= '0;
        end
        else
        begin
            if (embed_we)
            begin
                emb[operand_idx[1:0]] <= wdata;
            end
            if (neuron_we)
            begin
                h_new[neuron_idx] <= acc_value;
            end
            if (commit)
            begin
                h_old <= h_new;                             // Step result becomes state
            end
        end
    end

    assign operand = operand_from_embed ? emb[operand_idx[1:0]] : h_old[operand_idx];
    assign hidden  = h_old;

    a_embed_idx: assert property (@(posedge clk) disable iff (reset)
        operand_from_embed |-> operand_idx < rnn_pkg::EMBEDDING_SIZE)
        else $error("Embedding index out of range");

endmodule

`default_nettype wire

/* logic/mac_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_unit
(
    input  logic clk,
    input  logic reset,
    input  rnn_pkg::mac_op_t mac_op,
    input  rnn_pkg::word_t weight,
    input  rnn_pkg::word_t operand,
    output rnn_pkg::word_t acc_value
);

    logic signed [31:0] product;
    rnn_pkg::word_t product_q88;
    rnn_pkg::word_t acc;

    assign product     = weight * operand;
    assign product_q88 = rnn_pkg::word_t'(product >>> rnn_pkg::FRAC_BITS); // Truncate to Q8.8

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            acc <= '0;
        end
        else
        begin
            unique case (mac_op)
                rnn_pkg::MAC_CLEAR:
                begin
                    acc <= '0;
                end
                rnn_pkg::MAC_MUL:
                begin
                    acc <= acc + product_q88;               // Wraps at 16 bits
                end
                rnn_pkg::MAC_ADD:
                begin
                    acc <= acc + weight;                    // Bias term
                end
                default:
                begin
                    acc <= acc;
                end
            endcase
        end
    end

    assign acc_value = acc;

endmodule

`default_nettype wire

/* logic/rnn_cell_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rnn_cell_top
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic [rnn_pkg::TOKEN_W-1:0] token,
    output logic busy,
    output logic step_done,
    output rnn_pkg::hidden_vec_t hidden,
    output rnn_pkg::mem_req_t mem_req,
    input  rnn_pkg::mem_rsp_t mem_rsp
);

    rnn_pkg::param_req_t param_req;
    rnn_pkg::mac_op_t mac_op;
    rnn_pkg::word_t fetch_data;
    rnn_pkg::word_t operand;
    rnn_pkg::word_t acc_value;
    logic fetch_done;
    logic embed_we;
    logic neuron_we;
    logic [2:0] neuron_idx;
    logic [2:0] operand_idx;
    logic operand_from_embed;
    logic commit;

    weight_fetch i_weight_fetch
    (
        .clk(clk),
        .reset(reset),
        .param_req(param_req),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp),
        .fetch_done(fetch_done),
        .fetch_data(fetch_data)
    );

    step_sequencer i_step_sequencer
    (
        .clk(clk),
        .reset(reset),
        .start(start),
        .token(token),
        .busy(busy),
        .step_done(step_done),
        .param_req(param_req),
        .fetch_done(fetch_done),
        .mac_op(mac_op),
        .embed_we(embed_we),
        .neuron_we(neuron_we),
        .neuron_idx(neuron_idx),
        .operand_idx(operand_idx),
        .operand_from_embed(operand_from_embed),
        .commit(commit)
    );

    mac_unit i_mac_unit
    (
        .clk(clk),
        .reset(reset),
        .mac_op(mac_op),
        .weight(fetch_data),                                // Weight or bias word
        .operand(operand),
        .acc_value(acc_value)
    );

    hidden_state i_hidden_state
    (
        .clk(clk),
        .reset(reset),
        .embed_we(embed_we),
        .neuron_we(neuron_we),
        .neuron_idx(neuron_idx),
        .operand_idx(operand_idx),
        .operand_from_embed(operand_from_embed),
        .wdata(fetch_data),
        .acc_value(acc_value),
        .commit(commit),
        .operand(operand),
        .hidden(hidden)
    );

endmodule

`default_nettype wire

/* logic/rnn_pkg.sv */
`default_nettype none

package rnn_pkg;

    localparam int VOCAB_SIZE     = 76;
    localparam int EMBEDDING_SIZE = 4;
    localparam int LINEAR_SIZE    = 8;
    localparam int WORD_W         = 16;
    localparam int FRAC_BITS      = 8;
    localparam int ADDR_W         = 27;
    localparam int TOKEN_W        = 7;

    // Parameter memory map, one word per entry
    localparam int WIH_BASE  = VOCAB_SIZE * EMBEDDING_SIZE;
    localparam int WHH_BASE  = WIH_BASE + EMBEDDING_SIZE * LINEAR_SIZE;
    localparam int BIH_BASE  = WHH_BASE + LINEAR_SIZE * LINEAR_SIZE;
    localparam int BHH_BASE  = BIH_BASE + LINEAR_SIZE;
    localparam int MEM_DEPTH = BHH_BASE + LINEAR_SIZE;

    typedef logic signed [WORD_W-1:0] word_t;               // Q8.8
    typedef logic [ADDR_W-1:0] addr_t;
    typedef word_t [LINEAR_SIZE-1:0] hidden_vec_t;

    typedef enum logic [2:0] {
        EMBED,
        WIH,
        WHH,
        BIH,
        BHH
    } param_kind_t;

    typedef struct packed {
        logic valid;
        param_kind_t kind;
        logic [TOKEN_W-1:0] row;                            // Token or neuron
        logic [2:0] col;
    } param_req_t;

    typedef struct packed {
        logic req;
        addr_t addr;
    } mem_req_t;

    typedef struct packed {
        logic valid;
        word_t data;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        MAC_IDLE,
        MAC_CLEAR,
        MAC_MUL,
        MAC_ADD
    } mac_op_t;

endpackage

`default_nettype wire

/* logic/step_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module step_sequencer
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic [rnn_pkg::TOKEN_W-1:0] token,
    output logic busy,
    output logic step_done,
    output rnn_pkg::param_req_t param_req,
    input  logic fetch_done,
    output rnn_pkg::mac_op_t mac_op,
    output logic embed_we,
    output logic neuron_we,
    output logic [2:0] neuron_idx,
    output logic [2:0] operand_idx,
    output logic operand_from_embed,
    output logic commit
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_EMBED,
        S_CLEAR,
        S_WHH,
        S_BHH,
        S_WIH,
        S_BIH,
        S_WRITE,
        S_COMMIT
    } state_t;

    state_t state;
    logic [2:0] col;
    logic [2:0] neuron;
    logic [rnn_pkg::TOKEN_W-1:0] token_q;
    logic last_emb;
    logic last_hid;

    assign last_emb = col == 3'(rnn_pkg::EMBEDDING_SIZE - 1);
    assign last_hid = col == 3'(rnn_pkg::LINEAR_SIZE - 1);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= S_IDLE;
            col       <= '0;
            neuron    <= '0;
            step_done <= 1'b0;
        end
        else
        begin
            step_done <= 1'b0;
            unique case (state)
                S_IDLE:
                begin
                    col <= '0;
                    if (start)
                    begin
                        state <= S_EMBED;
                    end
                end
                S_EMBED:
                begin
                    if (fetch_done)
                    begin
                        col    <= last_emb ? 3'd0 : col + 3'd1;
                        neuron <= '0;
                        state  <= last_emb ? S_CLEAR : S_EMBED;
                    end
                end
                S_CLEAR:
                begin
                    col   <= '0;
                    state <= S_WHH;
                end
                S_WHH:
                begin
                    if (fetch_done)
                    begin
                        col   <= last_hid ? 3'd0 : col + 3'd1;
                        state <= last_hid ? S_BHH : S_WHH;
                    end
                end
                S_BHH:
                begin
                    if (fetch_done)
                    begin
                        state <= S_WIH;
                    end
                end
                S_WIH:
                begin
                    if (fetch_done)
                    begin
                        col   <= last_emb ? 3'd0 : col + 3'd1;
                        state <= last_emb ? S_BIH : S_WIH;
                    end
                end
                S_BIH:
                begin
                    if (fetch_done)
                    begin
                        state <= S_WRITE;                   // Let the bias add land
                    end
                end
                S_WRITE:
                begin
                    if (neuron == 3'(rnn_pkg::LINEAR_SIZE - 1))
                    begin
                        state <= S_COMMIT;
                    end
                    else
                    begin
                        neuron <= neuron + 3'd1;
                        state  <= S_CLEAR;
                    end
                end
                S_COMMIT:
                begin
                    step_done <= 1'b1;                      // Lines up with new hidden
                    state     <= S_IDLE;
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == S_IDLE && start)
        begin
            token_q <= token;
        end
    end

    always_comb
    begin
        param_req          = '0;
        param_req.col      = col;
        param_req.row      = {{(rnn_pkg::TOKEN_W - 3){1'b0}}, neuron};
        mac_op             = rnn_pkg::MAC_IDLE;
        operand_from_embed = 1'b0;
        unique case (state)
            S_EMBED:
            begin
                param_req.valid    = 1'b1;
                param_req.kind     = rnn_pkg::EMBED;
                param_req.row      = token_q;
                operand_from_embed = 1'b1;
            end
            S_CLEAR:
            begin
                mac_op = rnn_pkg::MAC_CLEAR;
            end
            S_WHH:
            begin
                param_req.valid = 1'b1;
                param_req.kind  = rnn_pkg::WHH;
                mac_op          = fetch_done ? rnn_pkg::MAC_MUL : rnn_pkg::MAC_IDLE;
            end
            S_BHH:
            begin
                param_req.valid = 1'b1;
                param_req.kind  = rnn_pkg::BHH;
                mac_op          = fetch_done ? rnn_pkg::MAC_ADD : rnn_pkg::MAC_IDLE;
            end
            S_WIH:
            begin
                param_req.valid    = 1'b1;
                param_req.kind     = rnn_pkg::WIH;
                operand_from_embed = 1'b1;
                mac_op             = fetch_done ? rnn_pkg::MAC_MUL : rnn_pkg::MAC_IDLE;
            end
            S_BIH:
            begin
                param_req.valid = 1'b1;
                param_req.kind  = rnn_pkg::BIH;
                mac_op          = fetch_done ? rnn_pkg::MAC_ADD : rnn_pkg::MAC_IDLE;
            end
            default:
            begin
            end
        endcase
    end

    assign busy        = state != S_IDLE;
    assign embed_we    = state == S_EMBED && fetch_done;
    assign neuron_we   = state == S_WRITE;
    assign commit      = state == S_COMMIT;
    assign neuron_idx  = neuron;
    assign operand_idx = col;

    a_token_range: assert property (@(posedge clk) disable iff (reset)
        start && !busy |-> token < rnn_pkg::VOCAB_SIZE)
        else $error("Token out of vocabulary");

endmodule

`default_nettype wire

/* logic/weight_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module weight_fetch
(
    input  logic clk,
    input  logic reset,
    input  rnn_pkg::param_req_t param_req,
    output rnn_pkg::mem_req_t mem_req,
    input  rnn_pkg::mem_rsp_t mem_rsp,
    output logic fetch_done,
    output rnn_pkg::word_t fetch_data
);

    int row_i;
    int col_i;
    rnn_pkg::addr_t addr_next;
    rnn_pkg::addr_t addr_q;
    logic req_q;

    assign row_i = int'(param_req.row);
    assign col_i = int'(param_req.col);

    always_comb
    begin
        unique case (param_req.kind)
            rnn_pkg::EMBED:
                addr_next = rnn_pkg::addr_t'(row_i * rnn_pkg::EMBEDDING_SIZE + col_i);
            rnn_pkg::WIH:
                addr_next = rnn_pkg::addr_t'(rnn_pkg::WIH_BASE
                                             + row_i * rnn_pkg::EMBEDDING_SIZE + col_i);
            rnn_pkg::WHH:
                addr_next = rnn_pkg::addr_t'(rnn_pkg::WHH_BASE
                                             + row_i * rnn_pkg::LINEAR_SIZE + col_i);
            rnn_pkg::BIH:
                addr_next = rnn_pkg::addr_t'(rnn_pkg::BIH_BASE + row_i);
            rnn_pkg::BHH:
                addr_next = rnn_pkg::addr_t'(rnn_pkg::BHH_BASE + row_i);
            default:
                addr_next = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            req_q <= 1'b0;
        end
        else if (!req_q && param_req.valid)
        begin
            req_q <= 1'b1;                                  // Launch read
        end
        else if (req_q && mem_rsp.valid)
        begin
            req_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!req_q && param_req.valid)
        begin
            addr_q <= addr_next;                            // Held until valid
        end
    end

    assign mem_req.req  = req_q;
    assign mem_req.addr = addr_q;
    assign fetch_done   = req_q && mem_rsp.valid;
    assign fetch_data   = mem_rsp.data;

    a_addr_stable: assert property (@(posedge clk) disable iff (reset)
        mem_req.req |-> mem_req.addr == addr_next)
        else $error("Address changed while read pending");

    a_addr_range: assert property (@(posedge clk) disable iff (reset)
        mem_req.req |-> mem_req.addr < rnn_pkg::MEM_DEPTH)
        else $error("Address outside parameter memory");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the RNN cell testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_rnn_cell \
    -f sim.f -o tb_rnn_cell || { echo "Build failed"; exit 1; }

output="$(./obj_dir/tb_rnn_cell)"
echo "$output"
echo "$output" | grep -qx "No errors" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* sim.f */
logic/rnn_pkg.sv
logic/weight_fetch.sv
logic/step_sequencer.sv
logic/mac_unit.sv
logic/hidden_state.sv
logic/rnn_cell_top.sv
sim/weight_memory_model.sv
sim/tb_rnn_cell.sv

/* sim/tb_rnn_cell.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rnn_cell;

    logic clk;
    logic reset;
    logic start;
    logic [rnn_pkg::TOKEN_W-1:0] token;
    logic busy;
    logic step_done;
    rnn_pkg::hidden_vec_t hidden;
    rnn_pkg::mem_req_t mem_req;
    rnn_pkg::mem_rsp_t mem_rsp;

    rnn_pkg::hidden_vec_t model_h;                          // Reference hidden state
    rnn_pkg::hidden_vec_t expected;
    logic [rnn_pkg::TOKEN_W-1:0] last_token;
    int accepted;
    int dones;
    int errors;
    int errors_before;
    int tests;
    int steps_checked;

    rnn_cell_top i_dut
    (
        .clk(clk),
        .reset(reset),
        .start(start),
        .token(token),
        .busy(busy),
        .step_done(step_done),
        .hidden(hidden),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp)
    );

    weight_memory_model i_mem
    (
        .clk(clk),
        .reset(reset),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            accepted <= 0;
            dones    <= 0;
        end
        else
        begin
            if (start && !busy)
            begin
                accepted <= accepted + 1;
            end
            if (step_done)
            begin
                dones <= dones + 1;
            end
        end
    end

    a_reset_clears: assert property (@(posedge clk)
        reset |=> !busy && !step_done && !mem_req.req && hidden == '0)
        else
        begin
            errors++;
            $display("** Error: after reset busy = %h, step_done = %h, mem_req.req = %h, hidden = %h",
                     $sampled(busy), $sampled(step_done), $sampled(mem_req.req), $sampled(hidden));
        end

    a_step_result: assert property (@(posedge clk) disable iff (reset)
        step_done |-> hidden == expected)
        else
        begin
            errors++;
            $display("** Error: hidden = %h, expected %h", $sampled(hidden), expected);
        end

    a_one_done: assert property (@(posedge clk) disable iff (reset)
        step_done |-> accepted == dones + 1)
        else
        begin
            errors++;
            $display("Step finished without a matching accepted start");
        end

    a_addr_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req.req && !mem_rsp.valid |=> mem_req.req && $stable(mem_req.addr))
        else
        begin
            errors++;
            $display("Memory request dropped or its address moved before the read data came");
        end

    function automatic rnn_pkg::word_t q88_mul(input rnn_pkg::word_t a, input rnn_pkg::word_t b);
        logic signed [31:0] p;
        p = 32'(a) * 32'(b);
        return p[23:8];                                     // Drop 8 fraction bits, keep 16
    endfunction

    function automatic rnn_pkg::hidden_vec_t next_hidden(input logic [6:0] tok,
                                                         input rnn_pkg::hidden_vec_t h);
        rnn_pkg::hidden_vec_t h_next;
        rnn_pkg::word_t sum;
        int emb_row;
        emb_row = int'(tok) * rnn_pkg::EMBEDDING_SIZE;
        for (int j = 0; j < rnn_pkg::LINEAR_SIZE; j++)
        begin
            sum = i_mem.mem[rnn_pkg::BHH_BASE + j] + i_mem.mem[rnn_pkg::BIH_BASE + j];
            for (int k = 0; k < rnn_pkg::LINEAR_SIZE; k++)
            begin
                sum += q88_mul(i_mem.mem[rnn_pkg::WHH_BASE + j * rnn_pkg::LINEAR_SIZE + k], h[k]);
            end
            for (int e = 0; e < rnn_pkg::EMBEDDING_SIZE; e++)
            begin
                sum += q88_mul(i_mem.mem[rnn_pkg::WIH_BASE + j * rnn_pkg::EMBEDDING_SIZE + e],
                               i_mem.mem[emb_row + e]);
            end
            h_next[j] = sum;
        end
        return h_next;
    endfunction

    function automatic logic [6:0] pick_token(input logic [6:0] prev);
        return 7'((int'(prev) + 1 + int'($urandom_range(74, 0))) % rnn_pkg::VOCAB_SIZE);
    endfunction

    task automatic wait_step_done();
        do
        begin
            @(negedge clk);
        end
        while (!step_done);
        @(negedge clk);                                     // Result is checked at the edge between
        steps_checked++;
    endtask

    task automatic run_step(input logic [6:0] tok, input bit poke_busy);
        expected = next_hidden(tok, model_h);
        @(negedge clk);
        start = 1'b1;
        token = tok;
        @(negedge clk);
        start = 1'b0;
        if (poke_busy)
        begin
            repeat (20) @(negedge clk);
            start = 1'b1;                                   // Must be ignored
            token = pick_token(tok);
            @(negedge clk);
            start = 1'b0;
        end
        wait_step_done();
        model_h    = expected;
        last_token = tok;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("Test %0d, %s: %s", tests, name, errors == errors_before ? "pass" : "FAIL");
        errors_before = errors;
    endtask

    // Worst case is about 720 cycles per step, 9 steps in the run
    initial
    begin
        repeat (9 * 1000 + 100) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("Errors found");
        $finish;
    end

    initial
    begin
        void'($urandom(32'h74921c33));
        reset         = 1'b1;
        start         = 1'b0;
        token         = '0;
        model_h       = '0;
        expected      = '0;
        last_token    = '0;
        errors        = 0;
        errors_before = 0;
        tests         = 0;
        steps_checked = 0;
        i_mem.fill_random();
        repeat (2) @(negedge clk);
        reset = 1'b0;
        repeat (3) @(negedge clk);
        finish_test("reset state");

        run_step(7'($urandom_range(75, 0)), 1'b0);
        finish_test("first step from zero state");

        repeat (3)
        begin
            run_step(pick_token(last_token), 1'b0);
        end
        finish_test("recurrence over three tokens");

        run_step(pick_token(last_token), 1'b1);
        repeat (20) @(negedge clk);
        a_idle_after_step: assert (!busy)
        else
        begin
            errors++;
            $display("** Error: busy = %h, expected 0 after the step", busy);
        end
        finish_test("start while busy ignored");

        repeat (2)
        begin
            run_step(pick_token(last_token), 1'b0);
        end
        finish_test("random read latency");

        @(negedge clk);
        start = 1'b1;
        token = pick_token(last_token);
        @(negedge clk);
        start = 1'b0;
        repeat (150) @(negedge clk);
        reset   = 1'b1;                                     // Abort mid step
        model_h = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        run_step(pick_token(last_token), 1'b0);
        finish_test("reset in mid step");

        $display("%0d tests run, %0d steps checked, %0d errors", tests, steps_checked, errors);
        if (errors == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/weight_memory_model.sv */
`timescale 1ns/1ps
`default_nettype none

module weight_memory_model
(
    input  logic clk,
    input  logic reset,
    input  rnn_pkg::mem_req_t mem_req,
    output rnn_pkg::mem_rsp_t mem_rsp
);

    rnn_pkg::word_t mem [rnn_pkg::MEM_DEPTH];
    logic [2:0] age;                                        // Cycles the read has waited
    logic [2:0] latency;

    task automatic fill_random();
        for (int a = 0; a < rnn_pkg::MEM_DEPTH; a++)
        begin
            mem[a] = rnn_pkg::word_t'(int'($urandom_range(511, 0)) - 256); // Q8.8 in [-1, 1)
        end
    endtask

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mem_rsp.valid <= 1'b0;
            age           <= '0;
            latency       <= 3'($urandom_range(4, 1));
        end
        else if (!mem_req.req)
        begin
            mem_rsp.valid <= 1'b0;
            age           <= '0;
        end
        else if (mem_rsp.valid)
        begin
            mem_rsp.valid <= 1'b0;
            latency       <= 3'($urandom_range(4, 1));      // For the next read
        end
        else if (age + 3'd1 == latency)
        begin
            mem_rsp.valid <= 1'b1;
            mem_rsp.data  <= mem[int'(mem_req.addr)];
        end
        else
        begin
            age <= age + 3'd1;
        end
    end

endmodule

`default_nettype wire
